//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_decode_stage
FILELIST = sources.f
OBJ_DIR  = obj_dir

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- decode_cfg.svh
// decode stage configuration
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// datapath and instruction widths
`define XLEN 64
`define ILEN 32

`define DECODE_WIDTH 2 // slots per fetch bundle
`define REG_ADDR_W 5

`endif

//--- decode_lane.sv
// RV64IM single slot decoder
`default_nettype none
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_lane
    import decode_pkg::*;
(
    input  fetch_slot_t slot_i,
    output decoded_t    decoded_o,
    output redirect_t   redirect_o
);

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] jal_target;
    logic             is_jal;
    logic             misaligned;
    logic             alt_ok;  // funct3 allowed with the alternate funct7
    logic             illegal;

    // alt selects SUB or SRA
    function automatic op_e alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? SUB : ADD;
            3'd1:    return SLL;
            3'd2:    return SLT;
            3'd3:    return SLTU;
            3'd4:    return XOR;
            3'd5:    return alt ? SRA : SRL;
            3'd6:    return OR;
            default: return AND;
        endcase
    endfunction

    function automatic op_e aluw_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? SUBW : ADDW;
            3'd1:    return SLLW;
            default: return alt ? SRAW : SRLW;
        endcase
    endfunction

    function automatic op_e muldiv_op(input logic [2:0] f3, input logic w);
        case (f3)
            3'd0:    return w ? MULW : MUL;
            3'd1:    return MULH;
            3'd2:    return MULHSU;
            3'd3:    return MULHU;
            3'd4:    return w ? DIVW : DIV;
            3'd5:    return w ? DIVUW : DIVU;
            3'd6:    return w ? REMW : REM;
            default: return w ? REMUW : REMU;
        endcase
    endfunction

    imm_gen imm_gen0 (
        .inst_i (slot_i.inst),
        .imm_o  (imm)
    );

    assign opcode = opcode_e'(slot_i.inst[6:0]);
    assign funct3 = slot_i.inst[14:12];
    assign funct7 = slot_i.inst[31:25];
    assign alt_ok = (funct3 == 3'd0) || (funct3 == 3'd5);

    assign is_jal     = slot_i.valid && !slot_i.ex.valid && (opcode == OP_JAL);
    assign jal_target = slot_i.pc + imm;
    assign misaligned = is_jal && (jal_target[1:0] != 2'b00);

    assign redirect_o.valid  = is_jal && !misaligned;
    assign redirect_o.target = jal_target;

    always_comb begin
        illegal              = 1'b0;
        decoded_o.valid      = slot_i.valid;
        decoded_o.pc         = slot_i.pc;
        decoded_o.rs1        = slot_i.inst[19:15];
        decoded_o.rs2        = slot_i.inst[24:20];
        decoded_o.rd         = slot_i.inst[11:7];
        decoded_o.op         = ADD;
        decoded_o.unit       = UNIT_ALU;
        decoded_o.use_imm    = 1'b0;
        decoded_o.use_pc     = 1'b0;
        decoded_o.op_32      = 1'b0;
        decoded_o.regfile_we = 1'b0;
        decoded_o.signed_op  = 1'b0;
        decoded_o.mem_size   = funct3;
        decoded_o.imm        = imm;

        if (slot_i.valid && !slot_i.ex.valid) begin
            case (opcode)
                OP_LUI: begin
                    decoded_o.regfile_we = 1'b1;
                    decoded_o.use_imm    = 1'b1;
                    decoded_o.rs1        = '0; // x0 | imm
                    decoded_o.op         = OR;
                end
                OP_AUIPC: begin
                    decoded_o.regfile_we = 1'b1;
                    decoded_o.use_imm    = 1'b1;
                    decoded_o.use_pc     = 1'b1;
                end
                OP_JAL, OP_JALR: begin
                    decoded_o.regfile_we = 1'b1; // link address
                    decoded_o.use_imm    = 1'b1;
                    decoded_o.use_pc     = 1'b1;
                    decoded_o.unit       = UNIT_BRANCH;
                    decoded_o.op         = (opcode == OP_JAL) ? JAL : JALR;
                    illegal              = (opcode == OP_JALR) && (funct3 != 3'd0);
                end
                OP_BRANCH: begin
                    decoded_o.use_imm = 1'b1;
                    decoded_o.use_pc  = 1'b1;
                    decoded_o.unit    = UNIT_BRANCH;
                    case (funct3)
                        3'd0:    decoded_o.op = BEQ;
                        3'd1:    decoded_o.op = BNE;
                        3'd4:    decoded_o.op = BLT;
                        3'd5:    decoded_o.op = BGE;
                        3'd6:    decoded_o.op = BLTU;
                        3'd7:    decoded_o.op = BGEU;
                        default: illegal = 1'b1;
                    endcase
                end
                OP_LOAD: begin
                    decoded_o.regfile_we = 1'b1;
                    decoded_o.use_imm    = 1'b1;
                    decoded_o.unit       = UNIT_MEM;
                    case (funct3)
                        3'd0:    decoded_o.op = LB;
                        3'd1:    decoded_o.op = LH;
                        3'd2:    decoded_o.op = LW;
                        3'd3:    decoded_o.op = LD;
                        3'd4:    decoded_o.op = LBU;
                        3'd5:    decoded_o.op = LHU;
                        3'd6:    decoded_o.op = LWU;
                        default: illegal = 1'b1;
                    endcase
                end
                OP_STORE: begin
                    decoded_o.use_imm = 1'b1;
                    decoded_o.unit    = UNIT_MEM;
                    case (funct3)
                        3'd0:    decoded_o.op = SB;
                        3'd1:    decoded_o.op = SH;
                        3'd2:    decoded_o.op = SW;
                        3'd3:    decoded_o.op = SD;
                        default: illegal = 1'b1;
                    endcase
                end
                OP_ALU_I: begin
                    decoded_o.regfile_we = 1'b1;
                    decoded_o.use_imm    = 1'b1;
                    decoded_o.op         = alu_op(funct3, (funct3 == 3'd5) && funct7[5]);
                    // 6-bit shamt leaves funct7[6:1] to check
                    if (funct3 == 3'd1) begin
                        illegal = (funct7[6:1] != F7_BASE[6:1]);
                    end else if (funct3 == 3'd5) begin
                        illegal = (funct7[6:1] != F7_BASE[6:1]) && (funct7[6:1] != F7_ALT[6:1]);
                    end
                end
                OP_ALU_I_W: begin
                    decoded_o.regfile_we = 1'b1;
                    decoded_o.use_imm    = 1'b1;
                    decoded_o.op_32      = 1'b1;
                    decoded_o.op         = aluw_op(funct3, (funct3 == 3'd5) && funct7[5]);
                    case (funct3)
                        3'd0:    illegal = 1'b0;
                        3'd1:    illegal = (funct7 != F7_BASE);
                        3'd5:    illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
                        default: illegal = 1'b1;
                    endcase
                end
                OP_ALU, OP_ALU_W: begin
                    decoded_o.regfile_we = 1'b1;
                    decoded_o.op_32      = (opcode == OP_ALU_W);
                    if (funct7 == F7_MULDIV) begin
                        decoded_o.op        = muldiv_op(funct3, opcode == OP_ALU_W);
                        decoded_o.unit      = funct3[2] ? UNIT_DIV : UNIT_MUL;
                        decoded_o.signed_op = funct3[2] && !funct3[0]; // DIV and REM
                        illegal = (opcode == OP_ALU_W) && !funct3[2] && (funct3 != 3'd0);
                    end else begin
                        decoded_o.op = (opcode == OP_ALU_W) ? aluw_op(funct3, funct7[5])
                                                            : alu_op(funct3, funct7[5]);
                        if (funct7 == F7_ALT) begin
                            illegal = !alt_ok;
                        end else if (funct7 == F7_BASE) begin
                            illegal = (opcode == OP_ALU_W) && !alt_ok && (funct3 != 3'd1);
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                end
                OP_MISC_MEM, OP_AMO, OP_SYSTEM: illegal = 1'b1; // not supported
                default: illegal = 1'b1;
            endcase
        end

        // misaligned jal wins over illegal
        if (slot_i.ex.valid) begin
            decoded_o.ex = slot_i.ex;
        end else if (misaligned) begin
            decoded_o.ex = '{valid: 1'b1, cause: INSTR_ADDR_MISALIGNED, origin: jal_target};
        end else if (illegal) begin
            decoded_o.ex = '{valid: 1'b1, cause: ILLEGAL_INSTR, origin: '0};
        end else begin
            decoded_o.ex = '{valid: 1'b0, cause: NONE, origin: '0};
        end
    end

endmodule

`default_nettype wire

//--- decode_pkg.sv
// decode stage types
`default_nettype none
`include "decode_cfg.svh"

package decode_pkg;

    // major opcodes, MISC_MEM, AMO and SYSTEM only to flag them illegal
    typedef enum logic [6:0] {
        OP_LOAD     = 7'b0000011,
        OP_MISC_MEM = 7'b0001111,
        OP_ALU_I    = 7'b0010011,
        OP_AUIPC    = 7'b0010111,
        OP_ALU_I_W  = 7'b0011011,
        OP_STORE    = 7'b0100011,
        OP_AMO      = 7'b0101111,
        OP_ALU      = 7'b0110011,
        OP_LUI      = 7'b0110111,
        OP_ALU_W    = 7'b0111011,
        OP_BRANCH   = 7'b1100011,
        OP_JALR     = 7'b1100111,
        OP_JAL      = 7'b1101111,
        OP_SYSTEM   = 7'b1110011
    } opcode_e;

    typedef enum logic [5:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        ADDW, SUBW, SLLW, SRLW, SRAW,
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
        MULW, DIVW, DIVUW, REMW, REMUW,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LD, LBU, LHU, LWU,
        SB, SH, SW, SD,
        JAL, JALR
    } op_e;

    typedef enum logic [2:0] {
        UNIT_ALU,
        UNIT_BRANCH,
        UNIT_MEM,
        UNIT_MUL,
        UNIT_DIV
    } unit_e;

    // mcause encodings, NONE is out of range
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'h0,
        ILLEGAL_INSTR         = 4'h2,
        NONE                  = 4'hf
    } xcpt_cause_e;

    typedef struct packed {
        logic             valid;
        xcpt_cause_e      cause;
        logic [`XLEN-1:0] origin;
    } xcpt_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [`ILEN-1:0] inst;
        xcpt_t            ex;    // raised at fetch
    } fetch_slot_t;

    typedef fetch_slot_t [`DECODE_WIDTH-1:0] fetch_bundle_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        op_e                    op;
        unit_e                  unit;
        logic                   use_imm;
        logic                   use_pc;
        logic                   op_32;
        logic                   regfile_we;
        logic                   signed_op;
        logic [2:0]             mem_size;  // funct3 of the access
        logic [`XLEN-1:0]       imm;
        xcpt_t                  ex;
    } decoded_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] target;
    } redirect_t;

    typedef decoded_t [`DECODE_WIDTH-1:0] decoded_bundle_t;

endpackage

`default_nettype wire

//--- decode_stage.sv
// two lane decode stage
`default_nettype none
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage
    import decode_pkg::*;
(
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            bundle_valid_i,
    input  fetch_bundle_t   bundle_i,
    output decoded_bundle_t decoded_o,
    output logic            decode_valid_o,
    output redirect_t       redirect_o
);

    fetch_bundle_t                 bundle_q;
    decoded_bundle_t               lane_decoded;
    redirect_t [`DECODE_WIDTH-1:0] lane_redirect;

    fetch_bundle_reg bundle_reg0 (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .bundle_valid_i (bundle_valid_i),
        .bundle_i       (bundle_i),
        .bundle_o       (bundle_q)
    );

    for (genvar g = 0; g < `DECODE_WIDTH; g++) begin : gen_lane
        decode_lane lane (
            .slot_i     (bundle_q[g]),
            .decoded_o  (lane_decoded[g]),
            .redirect_o (lane_redirect[g])
        );
    end

    redirect_arbiter arbiter0 (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .decoded_i      (lane_decoded),
        .redirect_req_i (lane_redirect),
        .decoded_o      (decoded_o),
        .decode_valid_o (decode_valid_o),
        .redirect_o     (redirect_o)
    );

endmodule

`default_nettype wire

//--- decode_stage_assert.sv
// decode stage assertions
`default_nettype none
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage_assert
    import decode_pkg::*;
(
    input logic            clk_i,
    input logic            reset_i,
    input logic            bundle_valid_i,
    input fetch_bundle_t   bundle_i,
    input decoded_bundle_t decoded_o,
    input logic            decode_valid_o,
    input redirect_t       redirect_o
);

    int               fail_count = 0;
    redirect_t        redirect_exp;
    logic             squash_exp;
    logic             misaligned_exp;
    logic [`XLEN-1:0] dest0;

    // pc plus the J-type offset
    function automatic logic [`XLEN-1:0] jal_dest(input fetch_slot_t s);
        logic [`XLEN-1:0] off;
        off = {{(`XLEN-21){s.inst[31]}}, s.inst[31], s.inst[19:12], s.inst[20],
               s.inst[30:21], 1'b0};
        return s.pc + off;
    endfunction

    function automatic logic is_jal(input fetch_slot_t s);
        return s.valid && !s.ex.valid && (s.inst[6:0] == 7'b1101111);
    endfunction

    always_comb begin
        redirect_exp = '0;
        for (int i = `DECODE_WIDTH-1; i >= 0; i--) begin // lowest slot ends up winning
            if (bundle_valid_i && is_jal(bundle_i[i]) &&
                ((jal_dest(bundle_i[i]) & 64'h3) == 64'h0)) begin
                redirect_exp.valid  = 1'b1;
                redirect_exp.target = jal_dest(bundle_i[i]);
            end
        end
    end

    assign dest0          = jal_dest(bundle_i[0]);
    assign squash_exp     = bundle_valid_i && is_jal(bundle_i[0]) && (dest0[1:0] == 2'b00);
    assign misaligned_exp = is_jal(bundle_i[0]) && (dest0[1:0] != 2'b00);

    a_reset_quiet: assert property (@(posedge clk_i)
        $past(reset_i) || $past(reset_i, 2) |-> !decode_valid_o && !redirect_o.valid &&
        !decoded_o[0].valid && !decoded_o[1].valid)
        else begin fail_count++; $error("outputs valid during or just after reset"); end

    a_latency0: assert property (@(posedge clk_i) disable iff (reset_i)
        decoded_o[0].valid == $past(bundle_valid_i && bundle_i[0].valid, 2))
        else begin fail_count++; $error("slot 0 valid not two cycles after strobe"); end

    a_latency1: assert property (@(posedge clk_i) disable iff (reset_i)
        decoded_o[1].valid == $past(bundle_valid_i && bundle_i[1].valid && !squash_exp, 2))
        else begin fail_count++; $error("slot 1 valid or squash wrong"); end

    // a squashing jal in slot 0 keeps slot 0 valid
    a_any_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        decode_valid_o == $past(bundle_valid_i && (bundle_i[0].valid || bundle_i[1].valid), 2))
        else begin fail_count++; $error("decode_valid_o wrong two cycles after strobe"); end

    a_redirect: assert property (@(posedge clk_i) disable iff (reset_i)
        redirect_o.valid == $past(redirect_exp.valid, 2) &&
        (!redirect_o.valid || redirect_o.target == $past(redirect_exp.target, 2)))
        else begin fail_count++; $error("redirect valid or target wrong"); end

    a_fetch_ex: assert property (@(posedge clk_i) disable iff (reset_i)
        decoded_o[0].valid && $past(bundle_i[0].ex.valid, 2) |->
        decoded_o[0].ex == $past(bundle_i[0].ex, 2))
        else begin fail_count++; $error("fetch exception not passed through"); end

    a_misaligned: assert property (@(posedge clk_i) disable iff (reset_i)
        decoded_o[0].valid && $past(misaligned_exp, 2) |-> decoded_o[0].ex.valid &&
        decoded_o[0].ex.cause == INSTR_ADDR_MISALIGNED &&
        decoded_o[0].ex.origin == $past(dest0, 2))
        else begin fail_count++; $error("misaligned jal exception wrong"); end

    a_illegal_origin: assert property (@(posedge clk_i) disable iff (reset_i)
        decoded_o[0].valid && decoded_o[0].ex.cause == ILLEGAL_INSTR &&
        !$past(bundle_i[0].ex.valid, 2) |-> decoded_o[0].ex.origin == '0)
        else begin fail_count++; $error("illegal instruction origin not zero"); end

endmodule

`default_nettype wire

//--- fetch_bundle_reg.sv
// fetch bundle input register
`default_nettype none
`timescale 1ns/1ps
`include "decode_cfg.svh"

module fetch_bundle_reg
    import decode_pkg::*;
(
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          bundle_valid_i,
    input  fetch_bundle_t bundle_i,
    output fetch_bundle_t bundle_o
);

    // payload taken every cycle, only the slot valids see reset
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `DECODE_WIDTH; i++) begin
            bundle_o[i] <= bundle_i[i];
            if (reset_i) begin
                bundle_o[i].valid <= 1'b0;
            end else begin
                bundle_o[i].valid <= bundle_i[i].valid & bundle_valid_i; // strobe qualified
            end
        end
    end

endmodule

`default_nettype wire

//--- imm_gen.sv
// immediate generator
`default_nettype none
`timescale 1ns/1ps
`include "decode_cfg.svh"

module imm_gen
    import decode_pkg::*;
(
    input  logic [`ILEN-1:0] inst_i,
    output logic [`XLEN-1:0] imm_o
);

    opcode_e          opcode;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    assign opcode = opcode_e'(inst_i[6:0]);

    assign imm_i = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{(`XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{(`XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {{(`XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
    assign imm_j = {{(`XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OP_JALR, OP_LOAD, OP_ALU_I, OP_ALU_I_W: imm_o = imm_i;
            OP_STORE:                               imm_o = imm_s;
            OP_BRANCH:                              imm_o = imm_b;
            OP_LUI, OP_AUIPC:                       imm_o = imm_u;
            OP_JAL:                                 imm_o = imm_j;
            default:                                imm_o = '0; // R-type and unknown
        endcase
    end

endmodule

`default_nettype wire

//--- redirect_arbiter.sv
// jal redirect arbiter and output register
`default_nettype none
`timescale 1ns/1ps
`include "decode_cfg.svh"

module redirect_arbiter
    import decode_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  decoded_bundle_t               decoded_i,
    input  redirect_t [`DECODE_WIDTH-1:0] redirect_req_i,
    output decoded_bundle_t               decoded_o,
    output logic                          decode_valid_o,
    output redirect_t                     redirect_o
);

    decoded_bundle_t          decoded_d;
    redirect_t                redirect_d;
    logic [`DECODE_WIDTH-1:0] slot_valid;
    logic                     squash;

    // slot 0 is oldest
    always_comb begin
        squash     = 1'b0;
        redirect_d = '0;
        decoded_d  = decoded_i;
        for (int i = 0; i < `DECODE_WIDTH; i++) begin
            if (squash) begin
                decoded_d[i].valid = 1'b0; // younger than the jal
            end else if (redirect_req_i[i].valid) begin
                redirect_d = redirect_req_i[i];
                squash     = 1'b1;
            end
            slot_valid[i] = decoded_d[i].valid;
        end
    end

    always_ff @(posedge clk_i) begin
        decoded_o         <= decoded_d;
        redirect_o.target <= redirect_d.target;
        if (reset_i) begin
            for (int i = 0; i < `DECODE_WIDTH; i++) begin
                decoded_o[i].valid <= 1'b0;
            end
            decode_valid_o   <= 1'b0;
            redirect_o.valid <= 1'b0;
        end else begin
            decode_valid_o   <= |slot_valid;
            redirect_o.valid <= redirect_d.valid;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
decode_pkg.sv
fetch_bundle_reg.sv
imm_gen.sv
decode_lane.sv
redirect_arbiter.sv
decode_stage.sv
decode_stage_assert.sv
tb_decode_stage.sv

//--- tb_decode_stage.sv
// decode stage testbench
`default_nettype none
`timescale 1ns/1ps
`include "decode_cfg.svh"

module tb_decode_stage
    import decode_pkg::*;
();

    localparam int NUM_RANDOM = 200;
    localparam logic [31:0] NOP = 32'h00000013;
    localparam logic [31:0] JAL16 = 32'h010000ef; // jal x1, +16

    logic            clk_i;
    logic            reset_i;
    logic            bundle_valid_i;
    fetch_bundle_t   bundle_i;
    decoded_bundle_t decoded_o;
    logic            decode_valid_o;
    redirect_t       redirect_o;

    string       name_t[$];
    logic [31:0] inst_t[$];
    logic [31:0] s1_t[$];
    logic [63:0] pc_t[$];
    logic        fex_t[$];
    op_e         op_t[$];
    unit_e       unit_t[$];
    xcpt_cause_e cause_t[$];
    logic [4:0]  flags_t[$]; // use_imm, use_pc, op_32, regfile_we, signed_op
    int          due_q[$];
    int          idx_q[$];
    int          cycle = 0;
    int          tb_errors = 0;
    int          seed = 91157;
    logic        table_done = 1'b0;

    decode_stage dut0 (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .bundle_valid_i (bundle_valid_i),
        .bundle_i       (bundle_i),
        .decoded_o      (decoded_o),
        .decode_valid_o (decode_valid_o),
        .redirect_o     (redirect_o)
    );

    bind decode_stage decode_stage_assert assert0 (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .bundle_valid_i (bundle_valid_i),
        .bundle_i       (bundle_i),
        .decoded_o      (decoded_o),
        .decode_valid_o (decode_valid_o),
        .redirect_o     (redirect_o)
    );

    task automatic add_case(input string n, input logic [31:0] inst, input logic [63:0] pc,
                            input logic fex, input logic [31:0] s1, input op_e op,
                            input unit_e unit, input xcpt_cause_e cause,
                            input logic [4:0] flags);
        name_t.push_back(n);
        inst_t.push_back(inst);
        pc_t.push_back(pc);
        fex_t.push_back(fex);
        s1_t.push_back(s1);
        op_t.push_back(op);
        unit_t.push_back(unit);
        cause_t.push_back(cause);
        flags_t.push_back(flags);
    endtask

    function automatic fetch_slot_t make_slot(input logic v, input logic [31:0] inst,
                                              input logic [63:0] pc, input logic fex);
        fetch_slot_t s;
        s.valid = v;
        s.pc    = pc;
        s.inst  = inst;
        s.ex    = fex ? xcpt_t'{1'b1, INSTR_ADDR_MISALIGNED, 64'h1234}
                      : xcpt_t'{1'b0, NONE, 64'h0};
        return s;
    endfunction

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle <= cycle + 1;

    // slot 0 of each directed bundle, two cycles after its strobe
    always @(negedge clk_i) begin
        int k;
        logic [4:0] flags;
        if (due_q.size() > 0 && due_q[0] == cycle) begin
            k = idx_q.pop_front();
            void'(due_q.pop_front());
            flags = {decoded_o[0].use_imm, decoded_o[0].use_pc, decoded_o[0].op_32,
                     decoded_o[0].regfile_we, decoded_o[0].signed_op};
            if (!decoded_o[0].valid) begin
                tb_errors++;
                $display("Error: %s gave no valid slot 0 output", name_t[k]);
            end else if (decoded_o[0].ex.cause != cause_t[k]) begin
                tb_errors++;
                $display("Mismatch %s: expected cause %s actual %s", name_t[k],
                         cause_t[k].name(), decoded_o[0].ex.cause.name());
            end else if (cause_t[k] == NONE && (decoded_o[0].op != op_t[k] ||
                         decoded_o[0].unit != unit_t[k] || flags != flags_t[k])) begin
                tb_errors++;
                $display("Mismatch %s: expected %s/%s/%05b actual %s/%s/%05b", name_t[k],
                         op_t[k].name(), unit_t[k].name(), flags_t[k], decoded_o[0].op.name(),
                         decoded_o[0].unit.name(), flags);
            end
        end
    end

    initial begin
        logic [31:0] inst;
        reset_i        = 1'b1;
        bundle_valid_i = 1'b0;
        bundle_i       = '0;
        add_case("add", 32'h002081b3, 64'h1000, 0, NOP, ADD, UNIT_ALU, NONE, 5'b00010);
        add_case("sub", 32'h402081b3, 64'h1000, 0, NOP, SUB, UNIT_ALU, NONE, 5'b00010);
        add_case("srai", 32'h4050d193, 64'h1000, 0, NOP, SRA, UNIT_ALU, NONE, 5'b10010);
        add_case("addiw", 32'h0010819b, 64'h1000, 0, NOP, ADDW, UNIT_ALU, NONE, 5'b10110);
        add_case("sraw", 32'h4020d1bb, 64'h1000, 0, NOP, SRAW, UNIT_ALU, NONE, 5'b00110);
        add_case("mul", 32'h022081b3, 64'h1000, 0, NOP, MUL, UNIT_MUL, NONE, 5'b00010);
        add_case("divu", 32'h0220d1b3, 64'h1000, 0, NOP, DIVU, UNIT_DIV, NONE, 5'b00010);
        add_case("rem", 32'h0220e1b3, 64'h1000, 0, NOP, REM, UNIT_DIV, NONE, 5'b00011);
        add_case("ld", 32'h0080b183, 64'h1000, 0, NOP, LD, UNIT_MEM, NONE, 5'b10010);
        add_case("sw", 32'h0020a223, 64'h1000, 0, NOP, SW, UNIT_MEM, NONE, 5'b10000);
        add_case("beq", 32'h00208463, 64'h1000, 0, NOP, BEQ, UNIT_BRANCH, NONE, 5'b11000);
        add_case("lui", 32'h123451b7, 64'h1000, 0, NOP, OR, UNIT_ALU, NONE, 5'b10010); // x0 | imm
        add_case("auipc", 32'h00001197, 64'h1000, 0, NOP, ADD, UNIT_ALU, NONE, 5'b11010);
        add_case("jalr", 32'h000100e7, 64'h1000, 0, NOP, JALR, UNIT_BRANCH, NONE, 5'b11010);
        add_case("system", 32'h00000073, 64'h1000, 0, NOP, ADD, UNIT_ALU, ILLEGAL_INSTR, 0);
        add_case("fence", 32'h0000000f, 64'h1000, 0, NOP, ADD, UNIT_ALU, ILLEGAL_INSTR, 0);
        add_case("amo", 32'h1000202f, 64'h1000, 0, NOP, ADD, UNIT_ALU, ILLEGAL_INSTR, 0);
        add_case("jalr_f3", 32'h000110e7, 64'h1000, 0, NOP, ADD, UNIT_ALU, ILLEGAL_INSTR, 0);
        add_case("slli_f7", 32'h40109193, 64'h1000, 0, NOP, ADD, UNIT_ALU, ILLEGAL_INSTR, 0);
        add_case("load_f3", 32'h0000f183, 64'h1000, 0, NOP, ADD, UNIT_ALU, ILLEGAL_INSTR, 0);
        add_case("unknown", 32'h0000007f, 64'h1000, 0, NOP, ADD, UNIT_ALU, ILLEGAL_INSTR, 0);
        add_case("fetch_ex", JAL16, 64'h1000, 1, NOP, ADD, UNIT_ALU, INSTR_ADDR_MISALIGNED, 0);
        add_case("jal_slot0", JAL16, 64'h1000, 0, NOP, JAL, UNIT_BRANCH, NONE, 5'b11010);
        add_case("jal_slot1", 32'h002081b3, 64'h1000, 0, JAL16, ADD, UNIT_ALU, NONE, 5'b00010);
        add_case("jal_misaligned", JAL16, 64'h1002, 0, NOP, JAL, UNIT_BRANCH,
                 INSTR_ADDR_MISALIGNED, 0);
        table_done = 1'b1;
        repeat (10) @(posedge clk_i);
        #1 reset_i = 1'b0;
        for (int i = 0; i < name_t.size(); i++) begin
            @(posedge clk_i);
            #1;
            bundle_valid_i = 1'b1;
            bundle_i[0]    = make_slot(1'b1, inst_t[i], pc_t[i], fex_t[i]);
            bundle_i[1]    = make_slot(1'b1, s1_t[i], pc_t[i] + 64'd4, 1'b0);
            due_q.push_back(cycle + 2);
            idx_q.push_back(i);
            if (i % 6 == 5) begin
                @(posedge clk_i);
                #1 bundle_valid_i = 1'b0; // idle gap
            end
        end
        for (int r = 0; r < NUM_RANDOM; r++) begin
            @(posedge clk_i);
            #1;
            bundle_valid_i = ($random(seed) & 3) != 0;
            for (int j = 0; j < `DECODE_WIDTH; j++) begin
                inst = $random(seed);
                if (($random(seed) & 3) == 0) inst[6:0] = 7'b1101111; // more jals
                bundle_i[j] = make_slot(($random(seed) & 1) != 0, inst,
                                        {$random(seed), $random(seed)} & ~64'h1,
                                        ($random(seed) & 7) == 0);
            end
        end
        @(posedge clk_i);
        #1 bundle_valid_i = 1'b0;
        repeat (3) @(posedge clk_i);
        $display("tb errors: %0d, assertion failures: %0d", tb_errors, dut0.assert0.fail_count);
        if (tb_errors + dut0.assert0.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        wait (table_done);
        #((name_t.size() + NUM_RANDOM + 20) * 8);
        $display("Error: timeout, the run did not finish in the expected time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
